// File: verilog/fb_macros.svh
`ifndef FB_MACROS_SVH
`define FB_MACROS_SVH

// horizontal position and visible width
`define FB_H_WIDTH 12

// vertical position and visible height
`define FB_V_WIDTH 12

// bits per colour channel, three channels per pixel
`define FB_COLOR_WIDTH 4

// byte address on the read port
`define FB_ADDR_WIDTH 16

// read data width, one pixel per beat
`define FB_DATA_WIDTH 16

// tag queue has 2**AW entries, scan stalls at half of that
`define FB_TAG_FIFO_AW 4

`endif

// File: verilog/fb_pkg.sv
`include "fb_macros.svh"

package fb_pkg;

  // scalar field types shared by tags and pixels
  typedef logic [`FB_H_WIDTH-1:0] fb_x_t;
  typedef logic [`FB_V_WIDTH-1:0] fb_y_t;
  typedef logic [`FB_ADDR_WIDTH-1:0] fb_addr_t;
  typedef logic [`FB_DATA_WIDTH-1:0] fb_data_t;
  typedef logic [`FB_COLOR_WIDTH-1:0] fb_color_t;

  // one outstanding read, pushed when the request is accepted
  typedef struct packed {
    fb_x_t    x;
    fb_y_t    y;
    fb_addr_t addr;
  } fb_tag_t;

  // one pixel on the output stream
  // colours come from the low three channels of the read beat,
  // red in the highest of them and blue in the lowest
  typedef struct packed {
    fb_color_t red;
    fb_color_t grn;
    fb_color_t blu;
    fb_x_t     x;
    fb_y_t     y;
    fb_addr_t  addr;
  } fb_pixel_t;

endpackage

// File: verilog/sync_fifo.sv
module sync_fifo #(
  parameter type T          = logic [7:0],
  parameter int  ADDR_WIDTH = 4
) (
  input  logic clk,
  input  logic rst_n,

  input  logic i_push,
  input  T     i_data,
  input  logic i_pop,

  output T     o_data,
  output logic o_empty,
  output logic o_full,
  output logic o_half_full
);

  localparam int DEPTH = 1 << ADDR_WIDTH;
  localparam int PW    = ADDR_WIDTH + 1;

  T mem [DEPTH];

  // pointers carry one extra wrap bit so full and empty differ
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;

  logic [PW-1:0] count;
  logic [PW-1:0] count_next;

  logic do_push;
  logic do_pop;

  // a push into a full buffer or a pop from an empty one is dropped
  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;

  assign o_empty = (wr_ptr == rd_ptr);
  assign o_full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

  // head entry is always visible
  assign o_data = mem[rd_ptr[ADDR_WIDTH-1:0]];

  assign count      = wr_ptr - rd_ptr;
  assign count_next = count + PW'(do_push) - PW'(do_pop);

  // half full looks at the occupancy after this cycle's update,
  // so a producer that reacts one cycle later never overshoots
  assign o_half_full = (count_next >= PW'(DEPTH / 2));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (do_push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (do_pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[ADDR_WIDTH-1:0]] <= i_data;
    end
  end

endmodule

// File: verilog/fb_scan.sv
`include "fb_macros.svh"

module fb_scan (
  input  logic              clk,
  input  logic              rst_n,

  input  fb_pkg::fb_x_t     i_h_visible,
  input  fb_pkg::fb_y_t     i_v_visible,

  output logic              o_arvalid,
  output fb_pkg::fb_addr_t  o_araddr,
  input  logic              i_arready,

  input  logic              i_tag_hold,
  output logic              o_tag_push,
  output fb_pkg::fb_tag_t   o_tag
);

  import fb_pkg::*;

  // one full-width beat per pixel
  localparam fb_addr_t ADDR_STEP = fb_addr_t'(`FB_DATA_WIDTH / 8);

  fb_x_t    x;
  fb_x_t    x_next;
  fb_x_t    x_last;

  fb_y_t    y;
  fb_y_t    y_next;
  fb_y_t    y_last;

  fb_addr_t addr;
  fb_addr_t addr_next;

  logic     arvalid_next;
  logic     accept;

  assign accept = o_arvalid && i_arready;

  assign x_last = i_h_visible - 1'b1;
  assign y_last = i_v_visible - 1'b1;

  // request valid holds until accepted, then re-arms
  // only while the tag queue has room
  always_comb begin
    arvalid_next = o_arvalid && !i_arready;
    if (!o_arvalid || i_arready) begin
      arvalid_next = !i_tag_hold;
    end
  end

  // raster walk, advanced once per accepted request
  always_comb begin
    x_next    = x;
    y_next    = y;
    addr_next = addr;

    if (accept) begin
      addr_next = addr + ADDR_STEP;
      if (x != x_last) begin
        x_next = x + 1'b1;
      end else begin
        x_next = '0;
        if (y != y_last) begin
          y_next = y + 1'b1;
        end else begin
          // end of frame
          y_next    = '0;
          addr_next = '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x         <= '0;
      y         <= '0;
      addr      <= '0;
      o_arvalid <= 1'b0;
    end else begin
      x         <= x_next;
      y         <= y_next;
      addr      <= addr_next;
      o_arvalid <= arvalid_next;
    end
  end

  assign o_araddr = addr;

  // tag follows the request it belongs to
  assign o_tag_push = accept;
  assign o_tag.x    = x;
  assign o_tag.y    = y;
  assign o_tag.addr = addr;

endmodule

// File: verilog/fb_pix_join.sv
`include "fb_macros.svh"

module fb_pix_join (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              i_tag_push,
  input  fb_pkg::fb_tag_t   i_tag,
  output logic              o_tag_hold,

  input  logic              i_rvalid,
  input  fb_pkg::fb_data_t  i_rdata,
  output logic              o_rready,

  input  logic              i_px_full,
  output logic              o_px_push,
  output fb_pkg::fb_pixel_t o_px
);

  import fb_pkg::*;

  localparam int CW = `FB_COLOR_WIDTH;

  fb_tag_t head_tag;
  logic    beat;

  // memory is only drained while the output stage has room
  assign o_rready = !i_px_full;
  assign beat     = i_rvalid && o_rready;

  // tags of reads in flight, oldest at the head
  sync_fifo #(
    .T          (fb_tag_t),
    .ADDR_WIDTH (`FB_TAG_FIFO_AW)
  ) u_tag_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_push      (i_tag_push),
    .i_data      (i_tag),
    .i_pop       (beat),
    .o_data      (head_tag),
    .o_empty     (),
    .o_full      (),
    .o_half_full (o_tag_hold)
  );

  // data returns in request order so the head tag always matches
  assign o_px_push  = beat;
  assign o_px.red   = i_rdata[3*CW-1 -: CW];
  assign o_px.grn   = i_rdata[2*CW-1 -: CW];
  assign o_px.blu   = i_rdata[CW-1:0];
  assign o_px.x     = head_tag.x;
  assign o_px.y     = head_tag.y;
  assign o_px.addr  = head_tag.addr;

endmodule

// File: verilog/fb_pix_out.sv
module fb_pix_out (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              i_px_push,
  input  fb_pkg::fb_pixel_t i_px,
  output logic              o_px_full,

  output logic              o_pix_valid,
  output fb_pkg::fb_pixel_t o_pix,
  input  logic              i_pix_ready
);

  import fb_pkg::*;

  logic px_empty;
  logic pix_taken;

  // a stream handshake frees the head entry
  assign pix_taken = o_pix_valid && i_pix_ready;

  // two entries, so the consumer's ready never reaches
  // the memory ready path combinationally
  sync_fifo #(
    .T          (fb_pixel_t),
    .ADDR_WIDTH (1)
  ) u_pix_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_push      (i_px_push),
    .i_data      (i_px),
    .i_pop       (pix_taken),
    .o_data      (o_pix),
    .o_empty     (px_empty),
    .o_full      (o_px_full),
    .o_half_full ()
  );

  assign o_pix_valid = !px_empty;

endmodule

// File: verilog/fb_pix_top.sv
module fb_pix_top (
  input  logic              clk,
  input  logic              rst_n,

  input  fb_pkg::fb_x_t     i_h_visible,
  input  fb_pkg::fb_y_t     i_v_visible,

  // read request channel
  output logic              o_arvalid,
  output fb_pkg::fb_addr_t  o_araddr,
  input  logic              i_arready,

  // read data channel
  input  logic              i_rvalid,
  input  fb_pkg::fb_data_t  i_rdata,
  output logic              o_rready,

  // pixel stream
  output logic              o_pix_valid,
  output fb_pkg::fb_pixel_t o_pix,
  input  logic              i_pix_ready
);

  import fb_pkg::*;

  logic      tag_push;
  fb_tag_t   tag;
  logic      tag_hold;

  logic      px_push;
  fb_pixel_t px;
  logic      px_full;

  fb_scan u_scan (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_h_visible (i_h_visible),
    .i_v_visible (i_v_visible),
    .o_arvalid   (o_arvalid),
    .o_araddr    (o_araddr),
    .i_arready   (i_arready),
    .i_tag_hold  (tag_hold),
    .o_tag_push  (tag_push),
    .o_tag       (tag)
  );

  fb_pix_join u_join (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_tag_push (tag_push),
    .i_tag      (tag),
    .o_tag_hold (tag_hold),
    .i_rvalid   (i_rvalid),
    .i_rdata    (i_rdata),
    .o_rready   (o_rready),
    .i_px_full  (px_full),
    .o_px_push  (px_push),
    .o_px       (px)
  );

  fb_pix_out u_out (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_px_push   (px_push),
    .i_px        (px),
    .o_px_full   (px_full),
    .o_pix_valid (o_pix_valid),
    .o_pix       (o_pix),
    .i_pix_ready (i_pix_ready)
  );

endmodule

// File: verification/axi_rd_mem_model.sv
module axi_rd_mem_model #(
  parameter logic [31:0] SEED = 32'he5fd7b6e
) (
  input  logic             clk,
  input  logic             rst_n,

  input  logic             i_arvalid,
  input  fb_pkg::fb_addr_t i_araddr,
  output logic             o_arready,

  output logic             o_rvalid,
  output fb_pkg::fb_data_t o_rdata,
  input  logic             i_rready
);

  timeunit 1ns;
  timeprecision 1ps;

  import fb_pkg::*;

  // addresses of accepted requests, answered in order
  fb_addr_t addr_q[$];
  integer   seed;
  int       wait_cnt;

  // memory contents are a fixed hash of the byte address
  function automatic fb_data_t mem_word(fb_addr_t addr);
    logic [31:0] prod;
    prod = 32'(addr) * 32'h9E37;
    return fb_data_t'(prod[15:0] ^ 16'h5A5A);
  endfunction

  initial begin
    seed      = SEED;
    wait_cnt  = 0;
    o_arready = 1'b0;
    o_rvalid  = 1'b0;
    o_rdata   = '0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        o_arready <= 1'b0;
        o_rvalid  <= 1'b0;
        wait_cnt  = 0;
        addr_q.delete();
      end else begin
        if (i_arvalid && o_arready) begin
          addr_q.push_back(i_araddr);
        end
        // request stall about one cycle in four
        o_arready <= (($random(seed) & 3) != 0);

        if (o_rvalid && !i_rready) begin
          // beat stays on the bus until taken
        end else if (wait_cnt != 0) begin
          o_rvalid <= 1'b0;
          wait_cnt = wait_cnt - 1;
        end else if (addr_q.size() > 0) begin
          o_rvalid <= 1'b1;
          o_rdata  <= mem_word(addr_q.pop_front());
          wait_cnt = $random(seed) & 3;
        end else begin
          o_rvalid <= 1'b0;
        end
      end
    end
  end

endmodule

// File: verification/fb_pix_tb.sv
`include "fb_macros.svh"

module fb_pix_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import fb_pkg::*;

  localparam int H_VIS          = 8;
  localparam int V_VIS          = 4;
  localparam int NUM_PIXELS     = 3 * H_VIS * V_VIS;
  localparam int TIMEOUT_CYCLES = 3000;
  // tag queue stall point plus the two output entries
  localparam int OUT_LIMIT      = (1 << `FB_TAG_FIFO_AW) / 2 + 2;

  logic      clk = 1'b0;
  logic      rst_n;
  fb_x_t     h_visible;
  fb_y_t     v_visible;
  logic      arvalid;
  fb_addr_t  araddr;
  logic      arready;
  logic      rvalid;
  fb_data_t  rdata;
  logic      rready;
  logic      pix_valid;
  fb_pixel_t pix;
  logic      pix_ready;

  integer    seed;
  int        errors = 0;
  int        pix_count = 0;
  int        req_count = 0;
  int        cycles = 0;
  fb_pixel_t exp_px;
  fb_pixel_t exp_req;
  logic      hold_valid;
  logic      hold_ready;
  fb_pixel_t hold_pix;
  logic      hold_arvalid;
  logic      hold_arready;
  fb_addr_t  hold_araddr;

  always #20 clk = ~clk;

  fb_pix_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_h_visible (h_visible),
    .i_v_visible (v_visible),
    .o_arvalid   (arvalid),
    .o_araddr    (araddr),
    .i_arready   (arready),
    .i_rvalid    (rvalid),
    .i_rdata     (rdata),
    .o_rready    (rready),
    .o_pix_valid (pix_valid),
    .o_pix       (pix),
    .i_pix_ready (pix_ready)
  );

  axi_rd_mem_model u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_arvalid (arvalid),
    .i_araddr  (araddr),
    .o_arready (arready),
    .o_rvalid  (rvalid),
    .o_rdata   (rdata),
    .i_rready  (rready)
  );

  // expected pixel n of an endless raster walk over an h by v frame
  function automatic fb_pixel_t expected_pixel(int idx, int h, int v);
    fb_pixel_t   px;
    int          pos;
    logic [31:0] word;
    pos     = idx % (h * v);
    px.x    = fb_x_t'(pos % h);
    px.y    = fb_y_t'(pos / h);
    px.addr = fb_addr_t'(pos * 2);
    word    = (32'(px.addr) * 32'h9E37) ^ 32'h5A5A;
    px.red  = word[11:8];
    px.grn  = word[7:4];
    px.blu  = word[3:0];
    return px;
  endfunction

  task automatic check_field(string name, logic [63:0] exp, logic [63:0] act);
    assert (exp == act) else begin
      errors++;
      $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  task automatic print_summary();
    $display("summary: %0d errors, %0d of %0d pixels, %0d requests",
             errors, pix_count, NUM_PIXELS, req_count);
  endtask

  // compare every request and pixel handshake and watch the channel rules
  always @(posedge clk) begin
    if (!rst_n) begin
      hold_valid   <= 1'b0;
      hold_ready   <= 1'b0;
      hold_arvalid <= 1'b0;
      hold_arready <= 1'b0;
    end else begin
      if (arvalid && arready) begin
        exp_req = expected_pixel(req_count, H_VIS, V_VIS);
        check_field("o_araddr", exp_req.addr, araddr);
        req_count <= req_count + 1;
      end
      // a stalled request must keep its address
      if (hold_arvalid && !hold_arready) begin
        assert (arvalid) else begin
          errors++;
          $display("%0t read request withdrawn before it was accepted", $time);
        end
        check_field("o_araddr", hold_araddr, araddr);
      end
      if (pix_valid && pix_ready) begin
        exp_px = expected_pixel(pix_count, H_VIS, V_VIS);
        check_field("o_pix.x", exp_px.x, pix.x);
        check_field("o_pix.y", exp_px.y, pix.y);
        check_field("o_pix.addr", exp_px.addr, pix.addr);
        check_field("o_pix.red", exp_px.red, pix.red);
        check_field("o_pix.grn", exp_px.grn, pix.grn);
        check_field("o_pix.blu", exp_px.blu, pix.blu);
        pix_count <= pix_count + 1;
      end
      // a stalled pixel must stay put
      if (hold_valid && !hold_ready) begin
        assert (pix_valid) else begin
          errors++;
          $display("%0t pixel valid dropped before it was taken", $time);
        end
        check_field("o_pix", hold_pix, pix);
      end
      assert (req_count - pix_count <= OUT_LIMIT) else begin
        errors++;
        $display("%0t too many reads in flight: %0d requests, %0d pixels",
                 $time, req_count, pix_count);
      end
      hold_valid   <= pix_valid;
      hold_ready   <= pix_ready;
      hold_pix     <= pix;
      hold_arvalid <= arvalid;
      hold_arready <= arready;
      hold_araddr  <= araddr;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      errors++;
      $display("timeout after %0d cycles, pixel stream stalled", cycles);
      print_summary();
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    seed      = 32'he5fd7b6e;
    rst_n     = 1'b0;
    pix_ready = 1'b0;
    h_visible = fb_x_t'(H_VIS);
    v_visible = fb_y_t'(V_VIS);

    repeat (10) @(posedge clk);
    rst_n     <= 1'b1;
    pix_ready <= 1'b1;
    @(negedge clk);
    assert (!arvalid && !pix_valid && rready) else begin
      errors++;
      $display("%0t outputs not idle right after reset", $time);
    end

    // free running for most of the first frame
    wait (pix_count >= 24);
    @(posedge clk);
    pix_ready <= 1'b0;
    repeat (40) @(posedge clk);
    pix_ready <= 1'b1;

    // random consumer for the rest
    while (pix_count < NUM_PIXELS) begin
      @(posedge clk);
      pix_ready <= (($random(seed) & 3) != 0);
    end
    pix_ready <= 1'b1;
    repeat (4) @(posedge clk);

    print_summary();
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+verilog
verilog/fb_pkg.sv
verilog/sync_fifo.sv
verilog/fb_scan.sv
verilog/fb_pix_join.sv
verilog/fb_pix_out.sv
verilog/fb_pix_top.sv
verification/axi_rd_mem_model.sv
verification/fb_pix_tb.sv
